/* source/LsuPkg.sv */
package LsuPkg;

    localparam int LineBytes = 16;

    typedef logic [31:0] word_t;
    typedef logic [LineBytes*8-1:0] line_t;
    typedef logic [31-$clog2(LineBytes):0] lineAddr_t;
    typedef logic [LineBytes-1:0] byteMask_t;

    typedef enum logic [2:0] {
        LsuCommand_Load = 3'h0,
        LsuCommand_Store = 3'h1,
        LsuCommand_LoadReserved = 3'h2,
        LsuCommand_StoreConditional = 3'h3,
        LsuCommand_AtomicMemOp = 3'h4,
        LsuCommand_Invalidate = 3'h5
    } LsuCommand;

    typedef enum logic [3:0] {
        AtomicOp_Swap = 4'h0,
        AtomicOp_Add = 4'h1,
        AtomicOp_Xor = 4'h2,
        AtomicOp_And = 4'h3,
        AtomicOp_Or = 4'h4,
        AtomicOp_Min = 4'h5,
        AtomicOp_Max = 4'h6,
        AtomicOp_Minu = 4'h7,
        AtomicOp_Maxu = 4'h8
    } AtomicOp;

    typedef enum logic [1:0] {
        AccessSize_Byte = 2'h0,
        AccessSize_Half = 2'h1,
        AccessSize_Word = 2'h2
    } AccessSize;

    typedef struct packed {
        LsuCommand command;
        AtomicOp atomicOp;
        AccessSize size;
        logic isUnsigned;
        logic [31:0] addr;
        word_t storeData;
    } lsuRequest_t;

    typedef struct packed {
        logic write;
        lineAddr_t lineAddr;
        line_t writeLine;
    } memRequest_t;

    typedef struct packed {
        logic valid;
        logic reserved;
        lineAddr_t lineAddr;
    } tagEntry_t;

endpackage

/* source/TagArray.sv */
`timescale 1ns/1ps

module TagArray import LsuPkg::*; #(
    parameter int IndexWidth = 6
) (
    input  logic clk,
    input  logic rst,
    input  logic [IndexWidth-1:0] index,
    input  logic write,
    input  tagEntry_t writeEntry,
    output tagEntry_t readEntry
);
    localparam int Depth = 1 << IndexWidth;

    tagEntry_t entries [Depth];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < Depth; i++) begin
                entries[i] <= '0;
            end
            readEntry <= '0;
        end
        else begin
            if (write) begin
                entries[index] <= writeEntry;
            end
            // Read returns the entry before a same-cycle write
            readEntry <= entries[index];
        end
    end

endmodule

/* source/LineDataArray.sv */
`timescale 1ns/1ps

module LineDataArray import LsuPkg::*; #(
    parameter int IndexWidth = 6
) (
    input  logic clk,
    input  logic [IndexWidth-1:0] index,
    input  byteMask_t writeMask,
    input  line_t writeLine,
    output line_t readLine
);
    localparam int Depth = 1 << IndexWidth;

    line_t lines [Depth];

    always_ff @(posedge clk) begin
        for (int b = 0; b < LineBytes; b++) begin
            if (writeMask[b]) begin
                lines[index][b*8 +: 8] <= writeLine[b*8 +: 8];
            end
        end
        readLine <= lines[index];
    end

endmodule

/* source/LoadAligner.sv */
`timescale 1ns/1ps

module LoadAligner import LsuPkg::*; (
    input  line_t line,
    input  logic [$clog2(LineBytes)-1:0] offset,
    input  AccessSize size,
    input  logic isUnsigned,
    output word_t value
);
    line_t shifted;
    word_t raw;

    assign shifted = line >> {offset, 3'b000};
    assign raw = shifted[31:0];

    always_comb begin
        unique case (size)
            AccessSize_Byte: begin
                value = {{24{!isUnsigned && raw[7]}}, raw[7:0]};
            end
            AccessSize_Half: begin
                value = {{16{!isUnsigned && raw[15]}}, raw[15:0]};
            end
            default: value = raw;
        endcase
    end

    // Natural alignment only, a line crossing is never split
    always_comb begin
        assert (!((size == AccessSize_Half && offset[0]) ||
                  (size == AccessSize_Word && offset[1:0] != 2'b00)))
            else $error("Misaligned access at offset %0d", offset);
    end

endmodule

/* source/StoreMerger.sv */
`timescale 1ns/1ps

module StoreMerger import LsuPkg::*; (
    input  lsuRequest_t request,
    input  word_t oldValue,
    output line_t line,
    output byteMask_t mask
);
    localparam int OffsetWidth = $clog2(LineBytes);

    word_t aluValue;
    word_t newValue;
    byteMask_t sizeMask;
    logic [OffsetWidth-1:0] offset;

    // Register operand against memory operand
    always_comb begin
        unique case (request.atomicOp)
            AtomicOp_Swap: aluValue = request.storeData;
            AtomicOp_Add: aluValue = request.storeData + oldValue;
            AtomicOp_Xor: aluValue = request.storeData ^ oldValue;
            AtomicOp_And: aluValue = request.storeData & oldValue;
            AtomicOp_Or: aluValue = request.storeData | oldValue;
            AtomicOp_Min: begin
                aluValue = ($signed(request.storeData) < $signed(oldValue))
                    ? request.storeData : oldValue;
            end
            AtomicOp_Max: begin
                aluValue = ($signed(request.storeData) > $signed(oldValue))
                    ? request.storeData : oldValue;
            end
            AtomicOp_Minu: aluValue = (request.storeData < oldValue) ? request.storeData : oldValue;
            AtomicOp_Maxu: aluValue = (request.storeData > oldValue) ? request.storeData : oldValue;
            default: aluValue = '0;
        endcase
    end

    assign newValue = (request.command == LsuCommand_AtomicMemOp) ? aluValue : request.storeData;
    assign offset = request.addr[OffsetWidth-1:0];

    always_comb begin
        unique case (request.size)
            AccessSize_Byte: sizeMask = byteMask_t'(4'b0001);
            AccessSize_Half: sizeMask = byteMask_t'(4'b0011);
            default: sizeMask = byteMask_t'(4'b1111);
        endcase
    end

    assign line = line_t'(newValue) << {offset, 3'b000};
    assign mask = sizeMask << offset;

endmodule

/* source/LineFillEngine.sv */
`timescale 1ns/1ps

module LineFillEngine import LsuPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic write,
    input  lineAddr_t lineAddr,
    input  line_t writeLine,
    output logic finish,
    output line_t fillLine,
    output logic memReq,
    output memRequest_t memRequest,
    input  logic memGrant,
    input  line_t memReadLine
);
    logic busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end
        else if (start) begin
            busy <= 1'b1;
        end
        else if (busy && memGrant) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            memRequest <= '{write: write, lineAddr: lineAddr, writeLine: writeLine};
        end
    end

    assign memReq = busy;
    assign finish = busy && memGrant;
    // Read data is only meaningful in the grant cycle
    assign fillLine = memReadLine;

    requestHeld: assert property (@(posedge clk) disable iff (rst)
        (memReq && !memGrant) |=> (memReq && $stable(memRequest)))
        else $error("Memory request changed before grant");

endmodule

/* source/LsuController.sv */
`timescale 1ns/1ps

module LsuController import LsuPkg::*; #(
    parameter int IndexWidth = 6
) (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  lsuRequest_t request,
    output logic done,
    output word_t result,
    output logic [IndexWidth-1:0] tagIndex,
    output logic tagWrite,
    output tagEntry_t tagWriteEntry,
    input  tagEntry_t tagReadEntry,
    output logic [IndexWidth-1:0] dataIndex,
    output byteMask_t dataWriteMask,
    output line_t dataWriteLine,
    input  line_t dataReadLine,
    input  word_t loadValue,
    input  line_t mergedLine,
    input  byteMask_t mergedMask,
    output logic fillStart,
    output logic fillWrite,
    output lineAddr_t fillLineAddr,
    output line_t fillWriteLine,
    input  logic fillFinish,
    input  line_t fillLine
);
    localparam int OffsetWidth = $clog2(LineBytes);

    typedef enum logic [2:0] {
        State_Idle,
        State_Lookup,
        State_Store,
        State_WriteThrough,
        State_Reserve,
        State_Refill,
        State_Invalidate
    } ControllerState;

    ControllerState state;
    ControllerState nextState;
    logic [IndexWidth-1:0] invIndex;
    word_t oldValue;

    lineAddr_t reqLineAddr;
    logic hit;
    logic scSuccess;
    logic lastIndex;
    line_t updatedLine;

    assign reqLineAddr = request.addr[31:OffsetWidth];
    assign hit = tagReadEntry.valid && (tagReadEntry.lineAddr == reqLineAddr);
    assign scSuccess = hit && tagReadEntry.reserved;
    assign lastIndex = (invIndex == {IndexWidth{1'b1}});

    // Whole line after the store for the write-through
    always_comb begin
        for (int b = 0; b < LineBytes; b++) begin
            updatedLine[b*8 +: 8] = mergedMask[b] ? mergedLine[b*8 +: 8]
                                                  : dataReadLine[b*8 +: 8];
        end
    end

    always_comb begin
        nextState = state;
        unique case (state)
            State_Idle: begin
                if (enable) begin
                    nextState = (request.command == LsuCommand_Invalidate) ? State_Invalidate
                                                                         : State_Lookup;
                end
            end
            State_Lookup: begin
                if (request.command == LsuCommand_StoreConditional) begin
                    nextState = scSuccess ? State_Store : State_Idle;
                end
                else if (!hit) begin
                    nextState = State_Refill;
                end
                else if (request.command == LsuCommand_LoadReserved) begin
                    nextState = State_Reserve;
                end
                else if (request.command == LsuCommand_Load) begin
                    nextState = State_Idle;
                end
                else begin
                    nextState = State_Store;
                end
            end
            State_Store: nextState = State_WriteThrough;
            State_WriteThrough: nextState = fillFinish ? State_Idle : State_WriteThrough;
            State_Reserve: nextState = State_Idle;
            State_Refill: nextState = fillFinish ? State_Idle : State_Refill;
            State_Invalidate: nextState = lastIndex ? State_Idle : State_Invalidate;
            default: nextState = State_Idle;
        endcase
    end

    always_comb begin
        done = 1'b0;
        unique case (state)
            State_Lookup: begin
                done = (request.command == LsuCommand_Load && hit) ||
                       (request.command == LsuCommand_StoreConditional && !scSuccess);
            end
            State_Reserve: done = 1'b1;
            State_WriteThrough: done = fillFinish;
            State_Invalidate: done = lastIndex;
            default: done = 1'b0;
        endcase
    end

    always_comb begin
        unique case (request.command)
            LsuCommand_StoreConditional: begin
                result = (state == State_WriteThrough) ? 32'd0 : 32'd1;
            end
            LsuCommand_LoadReserved, LsuCommand_AtomicMemOp: result = oldValue;
            LsuCommand_Load: result = loadValue;
            default: result = '0;
        endcase
    end

    // Array ports
    always_comb begin
        tagIndex = (state == State_Invalidate) ? invIndex
                                               : request.addr[OffsetWidth +: IndexWidth];
        dataIndex = tagIndex;
        tagWrite = 1'b0;
        tagWriteEntry = '{valid: 1'b1, reserved: 1'b0, lineAddr: reqLineAddr};
        dataWriteMask = '0;
        dataWriteLine = mergedLine;

        unique case (state)
            State_Store: begin
                tagWrite = 1'b1;
                dataWriteMask = mergedMask;
            end
            State_Reserve: begin
                tagWrite = 1'b1;
                tagWriteEntry.reserved = 1'b1;
            end
            State_Refill: begin
                tagWrite = fillFinish;
                dataWriteMask = fillFinish ? '1 : '0;
                dataWriteLine = fillLine;
            end
            State_Invalidate: begin
                tagWrite = 1'b1;
                tagWriteEntry = '0;
            end
            default: begin
            end
        endcase
    end

    // Refill read on a miss and write-through from the store state
    assign fillStart = (state == State_Store) ||
                       (state == State_Lookup && !hit &&
                        request.command != LsuCommand_StoreConditional);
    assign fillWrite = (state == State_Store);
    assign fillLineAddr = reqLineAddr;
    assign fillWriteLine = updatedLine;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= State_Idle;
            invIndex <= '0;
        end
        else begin
            state <= nextState;
            invIndex <= (state == State_Invalidate) ? invIndex + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == State_Lookup) begin
            oldValue <= loadValue;
        end
    end

    doneNeedsEnable: assert property (@(posedge clk) disable iff (rst) done |-> enable)
        else $error("done raised without enable");

    noWriteWithoutRequest: assert property (@(posedge clk) disable iff (rst)
        (tagWrite || (|dataWriteMask)) |-> enable)
        else $error("Array write while the core is idle");

endmodule

/* source/LoadStoreUnit.sv */
`timescale 1ns/1ps

module LoadStoreUnit import LsuPkg::*; #(
    parameter int IndexWidth = 6
) (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  lsuRequest_t request,
    output logic done,
    output word_t result,
    output logic memReq,
    output memRequest_t memRequest,
    input  logic memGrant,
    input  line_t memReadLine
);
    logic [IndexWidth-1:0] tagIndex;
    logic tagWrite;
    tagEntry_t tagWriteEntry;
    tagEntry_t tagReadEntry;

    logic [IndexWidth-1:0] dataIndex;
    byteMask_t dataWriteMask;
    line_t dataWriteLine;
    line_t dataReadLine;

    word_t loadValue;
    line_t mergedLine;
    byteMask_t mergedMask;

    logic fillStart;
    logic fillWrite;
    lineAddr_t fillLineAddr;
    line_t fillWriteLine;
    logic fillFinish;
    line_t fillLine;

    LsuController #(
        .IndexWidth(IndexWidth)
    ) controller (
        .clk,
        .rst,
        .enable,
        .request,
        .done,
        .result,
        .tagIndex,
        .tagWrite,
        .tagWriteEntry,
        .tagReadEntry,
        .dataIndex,
        .dataWriteMask,
        .dataWriteLine,
        .dataReadLine,
        .loadValue,
        .mergedLine,
        .mergedMask,
        .fillStart,
        .fillWrite,
        .fillLineAddr,
        .fillWriteLine,
        .fillFinish,
        .fillLine
    );

    TagArray #(
        .IndexWidth(IndexWidth)
    ) tagArray (
        .clk,
        .rst,
        .index(tagIndex),
        .write(tagWrite),
        .writeEntry(tagWriteEntry),
        .readEntry(tagReadEntry)
    );

    LineDataArray #(
        .IndexWidth(IndexWidth)
    ) dataArray (
        .clk,
        .index(dataIndex),
        .writeMask(dataWriteMask),
        .writeLine(dataWriteLine),
        .readLine(dataReadLine)
    );

    LoadAligner loadAligner (
        .line(dataReadLine),
        .offset(request.addr[$clog2(LineBytes)-1:0]),
        .size(request.size),
        .isUnsigned(request.isUnsigned),
        .value(loadValue)
    );

    // The array still holds the old line while the store is merged
    StoreMerger storeMerger (
        .request,
        .oldValue(loadValue),
        .line(mergedLine),
        .mask(mergedMask)
    );

    LineFillEngine fillEngine (
        .clk,
        .rst,
        .start(fillStart),
        .write(fillWrite),
        .lineAddr(fillLineAddr),
        .writeLine(fillWriteLine),
        .finish(fillFinish),
        .fillLine,
        .memReq,
        .memRequest,
        .memGrant,
        .memReadLine
    );

endmodule

/* verif/LsuTb.sv */
`timescale 1ns/1ps

module LsuTb import LsuPkg::*; ();
    localparam int IndexWidth = 6;
    localparam int CacheLines = 1 << IndexWidth;
    localparam logic [31:0] BaseAddr = 32'h0000_2000;
    localparam int LoadCount = 24;
    localparam int StoreCount = 6;
    localparam int NumOps = LoadCount + 2 * StoreCount + 9 + 7 + 3;
    localparam int CycleLimit = 40 * NumOps;

    logic clk;
    logic rst;
    logic enable;
    lsuRequest_t request;
    logic done;
    word_t result;
    logic memReq;
    memRequest_t memRequest;
    logic memGrant = 1'b0;
    line_t memReadLine = '0;

    // Expectations for the operation in flight
    logic started = 1'b0;
    logic checkResult = 1'b0;
    word_t expResult = '0;
    lineAddr_t expLineAddr = '0;
    line_t expLine = '0;
    int expReads = 0;
    int expWrites = 0;
    int readBase = 0;
    int writeBase = 0;
    int readGrants = 0;
    int writeGrants = 0;

    int errorCount = 0;
    int testErrorStart = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int cycleCount = 0;

    logic [31:0] stimLfsr = 32'h8890;
    logic [31:0] memLfsr = 32'h8890;
    bit grantPending = 1'b0;
    int grantWait = 0;

    line_t memModel [lineAddr_t];
    line_t refMem [lineAddr_t];
    logic cacheValid [CacheLines];
    lineAddr_t cacheTag [CacheLines];
    logic cacheRes [CacheLines];

    LoadStoreUnit #(
        .IndexWidth(IndexWidth)
    ) DUT (
        .clk,
        .rst,
        .enable,
        .request,
        .done,
        .result,
        .memReq,
        .memRequest,
        .memGrant,
        .memReadLine
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] stimBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = stimLfsr[0];
            stimLfsr = lfsrStep(stimLfsr);
        end
        return v;
    endfunction

    function automatic int grantDelay();
        int d;
        d = 0;
        for (int i = 0; i < 2; i++) begin
            d = d * 2 + int'(memLfsr[0]);
            memLfsr = lfsrStep(memLfsr);
        end
        return d;
    endfunction

    // Power-up contents, every word tied to its full byte address
    function automatic line_t initLine(lineAddr_t la);
        line_t l;
        logic [31:0] a;
        for (int w = 0; w < 4; w++) begin
            a = {la, 2'(w), 2'b00};
            l[32*w +: 32] = (a * 32'h0100_0193) ^ 32'hC3A5_5A3C;
        end
        return l;
    endfunction

    function automatic line_t modelLine(lineAddr_t la);
        return memModel.exists(la) ? memModel[la] : initLine(la);
    endfunction

    function automatic line_t refLine(lineAddr_t la);
        return refMem.exists(la) ? refMem[la] : initLine(la);
    endfunction

    function automatic logic [7:0] refByte(logic [31:0] addr);
        line_t l;
        l = refLine(addr[31:4]);
        return l[{addr[3:0], 3'b000} +: 8];
    endfunction

    function automatic int sizeBytes(AccessSize size);
        case (size)
            AccessSize_Byte: return 1;
            AccessSize_Half: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic void storeRef(logic [31:0] addr, AccessSize size, word_t data);
        line_t l;
        logic [31:0] a;
        for (int i = 0; i < sizeBytes(size); i++) begin
            a = addr + 32'(i);
            l = refLine(a[31:4]);
            l[{a[3:0], 3'b000} +: 8] = data[8*i +: 8];
            refMem[a[31:4]] = l;
        end
    endfunction

    // Little-endian gather, then fill the upper bytes
    function automatic word_t expectLoad(logic [31:0] addr, AccessSize size, logic uns);
        word_t v;
        int n;
        v = '0;
        n = sizeBytes(size);
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = refByte(addr + 32'(i));
        end
        if (!uns && v[8*n-1]) begin
            for (int i = n; i < 4; i++) begin
                v[8*i +: 8] = 8'hFF;
            end
        end
        return v;
    endfunction

    function automatic word_t amoResult(AtomicOp op, word_t mem, word_t operand);
        case (op)
            AtomicOp_Swap: return operand;
            AtomicOp_Add: return mem + operand;
            AtomicOp_Xor: return mem ^ operand;
            AtomicOp_And: return mem & operand;
            AtomicOp_Or: return mem | operand;
            AtomicOp_Min: return ($signed(mem) < $signed(operand)) ? mem : operand;
            AtomicOp_Max: return ($signed(mem) > $signed(operand)) ? mem : operand;
            AtomicOp_Minu: return (mem < operand) ? mem : operand;
            default: return (mem > operand) ? mem : operand;
        endcase
    endfunction

    function automatic AccessSize pickSize();
        case (stimBits(2))
            0: return AccessSize_Byte;
            1: return AccessSize_Half;
            default: return AccessSize_Word;
        endcase
    endfunction

    function automatic logic [31:0] pickAddr(int lineBits, AccessSize size);
        logic [31:0] a;
        a = BaseAddr + (stimBits(lineBits) << 4) + stimBits(4);
        if (size == AccessSize_Half) begin
            a[0] = 1'b0;
        end
        else if (size == AccessSize_Word) begin
            a[1:0] = 2'b00;
        end
        return a;
    endfunction

    // Memory model with a random grant delay of 0 to 3 cycles
    always @(posedge clk) begin
        if (rst) begin
            memGrant <= 1'b0;
            grantPending = 1'b0;
        end
        else if (memGrant) begin
            memGrant <= 1'b0;
        end
        else if (memReq) begin
            if (!grantPending) begin
                grantPending = 1'b1;
                grantWait = grantDelay();
            end
            if (grantWait == 0) begin
                grantPending = 1'b0;
                memGrant <= 1'b1;
                if (memRequest.write) begin
                    memModel[memRequest.lineAddr] = memRequest.writeLine;
                    writeGrants <= writeGrants + 1;
                end
                else begin
                    memReadLine <= modelLine(memRequest.lineAddr);
                    readGrants <= readGrants + 1;
                end
            end
            else begin
                grantWait = grantWait - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

    resetQuiet: assert property (@(posedge clk) disable iff (rst)
        !started |-> (!done && !memReq))
        else begin
            errorCount++;
            $display("done or memReq went high before the first request");
        end

    resultValue: assert property (@(posedge clk) disable iff (rst)
        (done && checkResult) |-> (result == expResult))
        else begin
            errorCount++;
            $display("mismatch result: got %h expected %h", $sampled(result),
                     $sampled(expResult));
        end

    readAddress: assert property (@(posedge clk) disable iff (rst)
        (memReq && memGrant && !memRequest.write) |-> (memRequest.lineAddr == expLineAddr))
        else begin
            errorCount++;
            $display("mismatch memRequest.lineAddr: got %h expected %h",
                     $sampled(memRequest.lineAddr), $sampled(expLineAddr));
        end

    writeAddress: assert property (@(posedge clk) disable iff (rst)
        (memReq && memGrant && memRequest.write) |-> (memRequest.lineAddr == expLineAddr))
        else begin
            errorCount++;
            $display("mismatch memRequest.lineAddr: got %h expected %h",
                     $sampled(memRequest.lineAddr), $sampled(expLineAddr));
        end

    writeLineValue: assert property (@(posedge clk) disable iff (rst)
        (memReq && memGrant && memRequest.write) |-> (memRequest.writeLine == expLine))
        else begin
            errorCount++;
            $display("mismatch memRequest.writeLine: got %h expected %h",
                     $sampled(memRequest.writeLine), $sampled(expLine));
        end

    // Counts settle one cycle after done
    readCount: assert property (@(posedge clk) disable iff (rst)
        done |=> (readGrants - readBase == expReads))
        else begin
            errorCount++;
            $display("mismatch read request count: got %h expected %h",
                     $sampled(readGrants) - $sampled(readBase), $sampled(expReads));
        end

    writeCount: assert property (@(posedge clk) disable iff (rst)
        done |=> (writeGrants - writeBase == expWrites))
        else begin
            errorCount++;
            $display("mismatch write request count: got %h expected %h",
                     $sampled(writeGrants) - $sampled(writeBase), $sampled(expWrites));
        end

    task automatic runOp(LsuCommand cmd, AtomicOp op, AccessSize size, logic uns,
                         logic [31:0] addr, word_t data);
        lineAddr_t la;
        int idx;
        logic hit;
        logic check;
        word_t old;
        word_t expValue;
        int reads;
        int writes;
        la = addr[31:4];
        idx = int'(addr[4 +: IndexWidth]);
        hit = cacheValid[idx] && (cacheTag[idx] == la);
        reads = 0;
        writes = 0;
        check = 1'b1;
        expValue = '0;
        if (cmd == LsuCommand_Invalidate) begin
            for (int i = 0; i < CacheLines; i++) begin
                cacheValid[i] = 1'b0;
                cacheRes[i] = 1'b0;
            end
            check = 1'b0;
        end
        else if (cmd == LsuCommand_StoreConditional) begin
            expValue = 32'd1;
            if (hit && cacheRes[idx]) begin
                storeRef(addr, AccessSize_Word, data);
                writes = 1;
                cacheRes[idx] = 1'b0;
                expValue = '0;
            end
        end
        else begin
            // Write-allocate, so every other miss refills first
            if (!hit) begin
                reads = 1;
                cacheValid[idx] = 1'b1;
                cacheTag[idx] = la;
                cacheRes[idx] = 1'b0;
            end
            old = expectLoad(addr, size, uns);
            expValue = old;
            if (cmd == LsuCommand_LoadReserved) begin
                cacheRes[idx] = 1'b1;
            end
            else if (cmd == LsuCommand_Store) begin
                storeRef(addr, size, data);
                writes = 1;
                cacheRes[idx] = 1'b0;
                check = 1'b0;
            end
            else if (cmd == LsuCommand_AtomicMemOp) begin
                storeRef(addr, AccessSize_Word, amoResult(op, old, data));
                writes = 1;
                cacheRes[idx] = 1'b0;
            end
        end

        @(posedge clk);
        enable <= 1'b1;
        request <= '{command: cmd, atomicOp: op, size: size, isUnsigned: uns,
                     addr: addr, storeData: data};
        started <= 1'b1;
        checkResult <= check;
        expResult <= expValue;
        expReads <= reads;
        expWrites <= writes;
        expLineAddr <= la;
        expLine <= refLine(la);
        readBase <= readGrants;
        writeBase <= writeGrants;
        do begin
            @(negedge clk);
        end while (!done);
        @(posedge clk);
        enable <= 1'b0;
    endtask

    task automatic reportTest(string name);
        repeat (2) @(negedge clk);
        testsRun++;
        if (errorCount == testErrorStart) begin
            $display("Test %0d %s: ok", testsRun, name);
        end
        else begin
            testsFailed++;
            $display("Test %0d %s: %0d errors", testsRun, name, errorCount - testErrorStart);
        end
        testErrorStart = errorCount;
    endtask

    initial begin
        logic [31:0] addr;
        AccessSize size;
        word_t data;
        logic uns;
        rst = 1'b1;
        enable = 1'b0;
        request = '0;
        for (int i = 0; i < CacheLines; i++) begin
            cacheValid[i] = 1'b0;
            cacheTag[i] = '0;
            cacheRes[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        repeat (4) @(posedge clk);
        reportTest("reset");

        for (int k = 0; k < LoadCount; k++) begin
            size = pickSize();
            addr = pickAddr(2, size);
            uns = 1'(stimBits(1));
            runOp(LsuCommand_Load, AtomicOp_Swap, size, uns, addr, '0);
        end
        reportTest("loads");

        for (int k = 0; k < StoreCount; k++) begin
            size = pickSize();
            addr = pickAddr(3, size);
            data = stimBits(32);
            runOp(LsuCommand_Store, AtomicOp_Swap, size, 1'b0, addr, data);
            uns = 1'(stimBits(1));
            runOp(LsuCommand_Load, AtomicOp_Swap, size, uns, addr, '0);
        end
        reportTest("stores");

        for (int k = 0; k < 9; k++) begin
            addr = pickAddr(3, AccessSize_Word);
            data = stimBits(32);
            runOp(LsuCommand_AtomicMemOp, AtomicOp'(k[3:0]), AccessSize_Word, 1'b0, addr, data);
        end
        reportTest("atomics");

        addr = BaseAddr + 32'h24;
        runOp(LsuCommand_LoadReserved, AtomicOp_Swap, AccessSize_Word, 1'b0, addr, '0);
        runOp(LsuCommand_StoreConditional, AtomicOp_Swap, AccessSize_Word, 1'b0, addr,
              32'h1234_5678);
        runOp(LsuCommand_StoreConditional, AtomicOp_Swap, AccessSize_Word, 1'b0, addr,
              32'h0BAD_F00D);
        runOp(LsuCommand_LoadReserved, AtomicOp_Swap, AccessSize_Word, 1'b0, addr, '0);
        runOp(LsuCommand_Store, AtomicOp_Swap, AccessSize_Byte, 1'b0, addr + 32'd1, 32'h5A);
        runOp(LsuCommand_StoreConditional, AtomicOp_Swap, AccessSize_Word, 1'b0, addr,
              32'hDEAD_BEEF);
        // Uncached line, no refill expected
        runOp(LsuCommand_StoreConditional, AtomicOp_Swap, AccessSize_Word, 1'b0,
              32'h0000_3000, 32'h1);
        reportTest("reservations");

        runOp(LsuCommand_Invalidate, AtomicOp_Swap, AccessSize_Word, 1'b0, 32'h0, '0);
        runOp(LsuCommand_Load, AtomicOp_Swap, AccessSize_Word, 1'b0, BaseAddr, '0);
        runOp(LsuCommand_Load, AtomicOp_Swap, AccessSize_Half, 1'b1, BaseAddr + 32'd6, '0);
        reportTest("invalidate");

        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("TEST PASSED");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
source/LsuPkg.sv
source/TagArray.sv
source/LineDataArray.sv
source/LoadAligner.sv
source/StoreMerger.sv
source/LineFillEngine.sv
source/LsuController.sv
source/LoadStoreUnit.sv
verif/LsuTb.sv

/* Makefile */
.PHONY: all run clean

all: run

obj_dir/VLsuTb: src.f $(shell cat src.f)
	verilator --binary --timing --assert --top-module LsuTb -o VLsuTb -f src.f

run: obj_dir/VLsuTb
	@out="$$(./obj_dir/VLsuTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
